/* Bender.yml */
package:
  name: pmp_checker

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/pmp_pkg.sv
      - source/pmp_rule_if.sv
      - source/pmp_rule_expand.sv
      - source/pmp_region_match.sv
      - source/pmp_access_ctrl.sv
      - source/pmp_top.sv

  - target: test
    include_dirs:
      - source
      - tests
    files:
      - tests/tb_pmp_top.sv

/* build.f */
+incdir+source
+incdir+tests
source/pmp_pkg.sv
source/pmp_rule_if.sv
source/pmp_rule_expand.sv
source/pmp_region_match.sv
source/pmp_access_ctrl.sv
source/pmp_top.sv
tests/tb_pmp_top.sv

/* source/pmp_access_ctrl.sv */
// PMP access control
// Applies privilege and rule permissions to the data and fetch paths,
// passing or blocking the request and grant strobes

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_access_ctrl (
   input  pmp_pkg::priv_lvl_e         priv_lvl_i,
   pmp_rule_if.ctrl                   rules_i,
   // Data path
   input  logic [`PMP_N_ENTRIES-1:0]  data_hit_i,
   input  logic                       data_req_i,
   input  logic                       data_we_i,
   input  logic                       data_gnt_i,
   output logic                       data_req_o,
   output logic                       data_gnt_o,
   output logic                       data_err_o,
   // Fetch path
   input  logic [`PMP_N_ENTRIES-1:0]  instr_hit_i,
   input  logic                       instr_req_i,
   input  logic                       instr_gnt_i,
   output logic                       instr_req_o,
   output logic                       instr_gnt_o,
   output logic                       instr_err_o
);
   import pmp_pkg::*;

   logic [`PMP_N_ENTRIES-1:0] data_perm_ok;
   logic [`PMP_N_ENTRIES-1:0] instr_perm_ok;
   logic                      m_mode;
   logic                      data_allow;
   logic                      instr_allow;

   // Store needs W, load needs R, fetch needs X
   always_comb
   begin
      for (int n = 0; n < `PMP_N_ENTRIES; n++)
      begin
         data_perm_ok[n]  = rules_i.rule_en[n] &
                            (data_we_i ? rules_i.rule_perm[n].w : rules_i.rule_perm[n].r);
         instr_perm_ok[n] = rules_i.rule_en[n] & rules_i.rule_perm[n].x;
      end
   end

   // Machine mode bypasses every rule
   assign m_mode      = (priv_lvl_i == PRIV_LVL_M);
   assign data_allow  = m_mode | (|(data_hit_i & data_perm_ok));
   assign instr_allow = m_mode | (|(instr_hit_i & instr_perm_ok));

   assign data_req_o  = data_allow & data_req_i;
   assign data_gnt_o  = data_allow & data_gnt_i;
   assign data_err_o  = ~data_allow & data_req_i;

   assign instr_req_o = instr_allow & instr_req_i;
   assign instr_gnt_o = instr_allow & instr_gnt_i;
   assign instr_err_o = ~instr_allow & instr_req_i;

endmodule

/* source/pmp_consts.svh */
// PMP checker sizing constants
// Rule count and the address widths shared by the RTL and the testbench model

`ifndef PMP_CONSTS_SVH
`define PMP_CONSTS_SVH

//////////////////////////////
// Rule table
//////////////////////////////

// Number of protection rules
`define PMP_N_ENTRIES 16

// Width of one rule config byte
`define PMP_CFG_W 8

//////////////////////////////
// Addresses
//////////////////////////////

// Byte address width on both access paths
`define PMP_XLEN 32

// Word address compared against the rules, bits 31 down to 2
`define PMP_WADDR_W 30

`endif

/* source/pmp_pkg.sv */
// PMP checker types
// Privilege levels, address-matching modes and the rule config byte

`include "pmp_consts.svh"

package pmp_pkg;

   // Privilege level of the current access
   typedef enum logic [1:0] {
      PRIV_LVL_U = 2'b00,
      PRIV_LVL_S = 2'b01,
      PRIV_LVL_M = 2'b11
   } priv_lvl_e;

   // Address-matching mode, the A field of a config byte
   typedef enum logic [1:0] {
      PMP_OFF   = 2'b00,
      PMP_TOR   = 2'b01,
      PMP_NA4   = 2'b10,
      PMP_NAPOT = 2'b11
   } pmp_mode_e;

   typedef struct packed {
      logic x;
      logic w;
      logic r;
   } pmp_perm_t;

   // Standard PMP config byte, L at the top and R at bit 0
   typedef struct packed {
      logic                     lock;
      logic [`PMP_CFG_W-7:0]    rsvd;
      pmp_mode_e                mode;
      pmp_perm_t                perm;
   } pmp_cfg_t;

endpackage

/* source/pmp_region_match.sv */
// PMP region matcher
// Compares one access address against every rule region and returns
// one hit bit per rule

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_region_match (
   input  logic [`PMP_XLEN-1:0]       addr_i,
   pmp_rule_if.matcher                rules_i,
   output logic [`PMP_N_ENTRIES-1:0]  hit_o
);
   import pmp_pkg::*;

   logic [`PMP_WADDR_W-1:0] word_addr;
   logic [`PMP_XLEN-1:0]    word_addr_ext;
   logic [`PMP_N_ENTRIES-1:0] region_hit;

   // Rules work on word addresses, byte offset dropped
   assign word_addr     = addr_i[`PMP_XLEN-1:2];
   assign word_addr_ext = {{(`PMP_XLEN-`PMP_WADDR_W){1'b0}}, word_addr};

   //////////////////////////////
   // Region compare
   //////////////////////////////
   always_comb
   begin
      for (int n = 0; n < `PMP_N_ENTRIES; n++)
      begin
         case (rules_i.rule_mode[n])
            PMP_TOR:
            begin
               // Upper bound is exclusive
               region_hit[n] = (word_addr_ext >= rules_i.rule_lo[n]) &&
                               (word_addr_ext <  rules_i.rule_hi[n]);
            end
            PMP_NA4:
            begin
               region_hit[n] = (word_addr == rules_i.rule_lo[n][`PMP_WADDR_W-1:0]);
            end
            PMP_NAPOT:
            begin
               region_hit[n] =
                  ((word_addr & rules_i.rule_mask[n][`PMP_WADDR_W-1:0]) ==
                   rules_i.rule_lo[n][`PMP_WADDR_W-1:0]);
            end
            default:
               region_hit[n] = 1'b0;
         endcase
      end
   end

   // A disabled rule never hits, whatever its stale bounds say
   assign hit_o = region_hit & rules_i.rule_en;

endmodule

/* source/pmp_rule_expand.sv */
// PMP rule expander
// Decodes the config bytes and pmpaddr words into per-rule bounds, masks
// and permissions, registered once per clock

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_rule_expand (
   input  logic                                       clk,
   input  logic                                       rst_i,
   input  logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0]   pmp_addr_i,
   input  pmp_pkg::pmp_cfg_t [`PMP_N_ENTRIES-1:0]     pmp_cfg_i,
   pmp_rule_if.expander                               rules_o
);
   import pmp_pkg::*;

   logic [`PMP_N_ENTRIES-1:0]                en_d;
   logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] lo_d;
   logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] hi_d;
   logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] mask_d;
   logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] tor_base;
   logic [`PMP_N_ENTRIES-1:0][5:0]           napot_ones;

   // Number of consecutive ones from bit 0, 32 for an all-ones word
   function automatic logic [5:0] trailing_ones(input logic [`PMP_XLEN-1:0] value);
      logic [5:0] count;
      logic       done;
      count = '0;
      done  = 1'b0;
      for (int b = 0; b < `PMP_XLEN; b++)
      begin
         if (!done && value[b])
            count = count + 6'd1;
         else
            done = 1'b1;
      end
      return count;
   endfunction

   // TOR region starts at the previous rule's address, rule 0 starts at zero
   always_comb
   begin
      tor_base[0] = '0;
      for (int n = 1; n < `PMP_N_ENTRIES; n++)
         tor_base[n] = pmp_addr_i[n-1];
   end

   //////////////////////////////
   // Per-rule decode
   //////////////////////////////
   always_comb
   begin
      for (int n = 0; n < `PMP_N_ENTRIES; n++)
      begin
         napot_ones[n] = trailing_ones(pmp_addr_i[n]);
         en_d[n]       = 1'b0;
         lo_d[n]       = pmp_addr_i[n];
         hi_d[n]       = pmp_addr_i[n];
         mask_d[n]     = '1;
         case (pmp_cfg_i[n].mode)
            PMP_TOR:
            begin
               en_d[n] = 1'b1;
               lo_d[n] = tor_base[n];
            end
            PMP_NA4:
               en_d[n] = 1'b1;
            PMP_NAPOT:
            begin
               // k trailing ones select a region of 2^(k+3) bytes
               en_d[n]   = (napot_ones[n] != 6'd32);
               mask_d[n] = {`PMP_XLEN{1'b1}} << (napot_ones[n] + 6'd1);
               lo_d[n]   = pmp_addr_i[n] & mask_d[n];
            end
            default:
               en_d[n] = 1'b0;
         endcase
      end
   end

   //////////////////////////////
   // Rule table registers
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst_i)
         rules_o.rule_en <= '0;
      else
         rules_o.rule_en <= en_d;
   end

   always_ff @(posedge clk)
   begin
      for (int n = 0; n < `PMP_N_ENTRIES; n++)
      begin
         rules_o.rule_mode[n] <= pmp_cfg_i[n].mode;
         rules_o.rule_perm[n] <= pmp_cfg_i[n].perm;
      end
      rules_o.rule_lo   <= lo_d;
      rules_o.rule_hi   <= hi_d;
      rules_o.rule_mask <= mask_d;
   end

endmodule

/* source/pmp_rule_if.sv */
// Expanded PMP rule table
// Written by the rule expander, read by the region matchers and the access control

`timescale 1ns/1ps

`include "pmp_consts.svh"

interface pmp_rule_if;
   import pmp_pkg::*;

   logic      [`PMP_N_ENTRIES-1:0]                rule_en;
   pmp_mode_e [`PMP_N_ENTRIES-1:0]                rule_mode;
   pmp_perm_t [`PMP_N_ENTRIES-1:0]                rule_perm;
   // Bounds and mask are in words, like the pmpaddr registers
   logic      [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] rule_lo;
   logic      [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] rule_hi;
   logic      [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] rule_mask;

   modport expander (
      output rule_en, rule_mode, rule_perm, rule_lo, rule_hi, rule_mask
   );

   modport matcher (
      input rule_en, rule_mode, rule_lo, rule_hi, rule_mask
   );

   modport ctrl (
      input rule_en, rule_perm
   );

endinterface

/* source/pmp_top.sv */
// PMP checker top level
// Checks data and fetch accesses against the registered rule table and
// forwards, or blocks with an error, the request and grant strobes

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_top (
   input  logic                                       clk,
   input  logic                                       rst_i,

   input  pmp_pkg::priv_lvl_e                         priv_lvl_i,
   input  logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0]   pmp_addr_i,
   input  pmp_pkg::pmp_cfg_t [`PMP_N_ENTRIES-1:0]     pmp_cfg_i,

   // Data side, pipeline
   input  logic                                       data_req_i,
   input  logic [`PMP_XLEN-1:0]                       data_addr_i,
   input  logic                                       data_we_i,
   output logic                                       data_gnt_o,
   // Data side, memory
   output logic                                       data_req_o,
   input  logic                                       data_gnt_i,
   output logic [`PMP_XLEN-1:0]                       data_addr_o,
   output logic                                       data_err_o,

   // Fetch side, pipeline
   input  logic                                       instr_req_i,
   input  logic [`PMP_XLEN-1:0]                       instr_addr_i,
   output logic                                       instr_gnt_o,
   // Fetch side, prefetch buffer
   output logic                                       instr_req_o,
   input  logic                                       instr_gnt_i,
   output logic [`PMP_XLEN-1:0]                       instr_addr_o,
   output logic                                       instr_err_o
);

   logic [`PMP_N_ENTRIES-1:0] data_hit;
   logic [`PMP_N_ENTRIES-1:0] instr_hit;

   pmp_rule_if rules ();

   //////////////////////////////
   // Rule table
   //////////////////////////////
   pmp_rule_expand i_rule_expand (
      .clk        ( clk        ),
      .rst_i      ( rst_i      ),
      .pmp_addr_i ( pmp_addr_i ),
      .pmp_cfg_i  ( pmp_cfg_i  ),
      .rules_o    ( rules      )
   );

   //////////////////////////////
   // Region matching
   //////////////////////////////
   pmp_region_match i_data_match (
      .addr_i  ( data_addr_i ),
      .rules_i ( rules       ),
      .hit_o   ( data_hit    )
   );

   pmp_region_match i_instr_match (
      .addr_i  ( instr_addr_i ),
      .rules_i ( rules        ),
      .hit_o   ( instr_hit    )
   );

   //////////////////////////////
   // Strobe gating
   //////////////////////////////
   pmp_access_ctrl i_access_ctrl (
      .priv_lvl_i  ( priv_lvl_i  ),
      .rules_i     ( rules       ),
      .data_hit_i  ( data_hit    ),
      .data_req_i  ( data_req_i  ),
      .data_we_i   ( data_we_i   ),
      .data_gnt_i  ( data_gnt_i  ),
      .data_req_o  ( data_req_o  ),
      .data_gnt_o  ( data_gnt_o  ),
      .data_err_o  ( data_err_o  ),
      .instr_hit_i ( instr_hit   ),
      .instr_req_i ( instr_req_i ),
      .instr_gnt_i ( instr_gnt_i ),
      .instr_req_o ( instr_req_o ),
      .instr_gnt_o ( instr_gnt_o ),
      .instr_err_o ( instr_err_o )
   );

   // Addresses pass unchanged, only the strobes are gated
   assign data_addr_o  = data_addr_i;
   assign instr_addr_o = instr_addr_i;

endmodule

/* tests/pmp_model.svh */
// PMP reference model
// Predicts the allow decision of one access straight from the PMP matching rules

`ifndef PMP_MODEL_SVH
`define PMP_MODEL_SVH

// Access kinds
localparam logic [1:0] ACC_LOAD  = 2'd0;
localparam logic [1:0] ACC_STORE = 2'd1;
localparam logic [1:0] ACC_FETCH = 2'd2;

// NAPOT word mask, the trailing ones and the zero above them are cleared
function automatic logic [31:0] napot_mask(input logic [31:0] pmp_addr);
   return ~(pmp_addr ^ (pmp_addr + 32'd1));
endfunction

// Does one rule cover the byte address
function automatic logic rule_covers(
   input pmp_cfg_t    cfg,
   input logic [31:0] pmp_addr,
   input logic [31:0] prev_addr,
   input logic [31:0] byte_addr
);
   logic [29:0] word;
   logic [31:0] mask;
   logic        hit;
   word = byte_addr[31:2];
   mask = napot_mask(pmp_addr);
   case (cfg.mode)
      PMP_TOR:
         hit = ({2'b00, word} >= prev_addr) && ({2'b00, word} < pmp_addr);
      PMP_NA4:
         hit = (word == pmp_addr[29:0]);
      PMP_NAPOT:
         // All ones leaves no zero bit to mark the size
         hit = (pmp_addr != '1) && ((word & mask[29:0]) == (pmp_addr[29:0] & mask[29:0]));
      default:
         hit = 1'b0;
   endcase
   return hit;
endfunction

// Any covering rule with the needed permission allows the access
function automatic logic access_allowed(
   input logic                                table_on,
   input priv_lvl_e                           priv,
   input pmp_cfg_t [`PMP_N_ENTRIES-1:0]       cfg,
   input logic [`PMP_N_ENTRIES-1:0][31:0]     addrs,
   input logic [31:0]                         byte_addr,
   input logic [1:0]                          kind
);
   logic        allowed;
   logic        perm_ok;
   logic [31:0] prev;
   allowed = (priv == PRIV_LVL_M);
   for (int n = 0; n < `PMP_N_ENTRIES; n++)
   begin
      prev = (n == 0) ? 32'd0 : addrs[n-1];
      case (kind)
         ACC_LOAD:  perm_ok = cfg[n].perm.r;
         ACC_STORE: perm_ok = cfg[n].perm.w;
         default:   perm_ok = cfg[n].perm.x;
      endcase
      if (table_on && perm_ok && rule_covers(cfg[n], addrs[n], prev, byte_addr))
         allowed = 1'b1;
   end
   return allowed;
endfunction

`endif

/* tests/tb_pmp_top.sv */
// Testbench for the PMP checker
// Random rules and accesses from an LFSR are checked cycle by cycle against
// a reference model of the rule table loaded one edge earlier

`timescale 1ns/1ps

`include "pmp_consts.svh"

module tb_pmp_top;
   import pmp_pkg::*;

   `include "pmp_model.svh"

   logic                                     clk;
   logic                                     rst_i;
   priv_lvl_e                                priv_lvl_i;
   logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] pmp_addr_i;
   pmp_cfg_t [`PMP_N_ENTRIES-1:0]            pmp_cfg_i;
   logic                                     data_req_i;
   logic [`PMP_XLEN-1:0]                     data_addr_i;
   logic                                     data_we_i;
   logic                                     data_gnt_i;
   logic                                     data_gnt_o;
   logic                                     data_req_o;
   logic [`PMP_XLEN-1:0]                     data_addr_o;
   logic                                     data_err_o;
   logic                                     instr_req_i;
   logic [`PMP_XLEN-1:0]                     instr_addr_i;
   logic                                     instr_gnt_i;
   logic                                     instr_gnt_o;
   logic                                     instr_req_o;
   logic [`PMP_XLEN-1:0]                     instr_addr_o;
   logic                                     instr_err_o;

   // Config to drive at the next edge
   pmp_cfg_t [`PMP_N_ENTRIES-1:0]            next_cfg;
   logic [`PMP_N_ENTRIES-1:0][`PMP_XLEN-1:0] next_addr;
   logic [31:0]                              lfsr_state;
   int                                       checks;
   int                                       mismatches;
   int                                       failures;

   pmp_top i_pmp_top (
      .clk          ( clk          ),
      .rst_i        ( rst_i        ),
      .priv_lvl_i   ( priv_lvl_i   ),
      .pmp_addr_i   ( pmp_addr_i   ),
      .pmp_cfg_i    ( pmp_cfg_i    ),
      .data_req_i   ( data_req_i   ),
      .data_addr_i  ( data_addr_i  ),
      .data_we_i    ( data_we_i    ),
      .data_gnt_o   ( data_gnt_o   ),
      .data_req_o   ( data_req_o   ),
      .data_gnt_i   ( data_gnt_i   ),
      .data_addr_o  ( data_addr_o  ),
      .data_err_o   ( data_err_o   ),
      .instr_req_i  ( instr_req_i  ),
      .instr_addr_i ( instr_addr_i ),
      .instr_gnt_o  ( instr_gnt_o  ),
      .instr_req_o  ( instr_req_o  ),
      .instr_gnt_i  ( instr_gnt_i  ),
      .instr_addr_o ( instr_addr_o ),
      .instr_err_o  ( instr_err_o  )
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int width);
      logic [31:0] value;
      logic        out_bit;
      value = '0;
      for (int i = 0; i < width; i++)
      begin
         out_bit    = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (out_bit)
            lfsr_state = lfsr_state ^ 32'hA300_0000;
         value = {value[30:0], out_bit};
      end
      return value;
   endfunction

   function automatic priv_lvl_e random_priv();
      logic [31:0] pick;
      pick = rand_bits(3);
      if (pick == 32'd7)
         return PRIV_LVL_M;
      else if (pick[0])
         return PRIV_LVL_S;
      else
         return PRIV_LVL_U;
   endfunction

   // Byte address a few words around a base word
   function automatic logic [31:0] near_addr(input logic [31:0] base_word);
      logic [31:0] word;
      logic [31:0] offs;
      word = base_word + rand_bits(3) - 32'd4;
      offs = rand_bits(2);
      return {word[29:0], offs[1:0]};
   endfunction

   // First word, last word, one past or one before the region
   function automatic logic [31:0] edge_word(input logic [31:0] lo, input logic [63:0] size);
      logic [31:0] pick;
      logic [31:0] span;
      pick = rand_bits(2);
      span = size[31:0] - 32'd1;
      case (pick[1:0])
         2'd0:    return lo;
         2'd1:    return lo + span;
         2'd2:    return lo + span + 32'd1;
         default: return lo - 32'd1;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         mismatches++;
         $display("mismatch %s at %0t: got 0x%08h, expected 0x%08h", name, $time, got, exp);
      end
   endtask

   //////////////////////////////
   // Drive one cycle and check it
   //////////////////////////////
   task automatic apply_cycle(
      input priv_lvl_e   priv,
      input logic        d_req,
      input logic [31:0] d_addr,
      input logic        d_we,
      input logic        d_gnt,
      input logic        f_req,
      input logic [31:0] f_addr,
      input logic        f_gnt
   );
      pmp_cfg_t [`PMP_N_ENTRIES-1:0]     tbl_cfg;
      logic [`PMP_N_ENTRIES-1:0][31:0]   tbl_addr;
      logic                              tbl_on;
      logic                              d_ok;
      logic                              f_ok;
      @(posedge clk);
      // The DUT loads its table from the values present at this edge
      tbl_cfg      = pmp_cfg_i;
      tbl_addr     = pmp_addr_i;
      tbl_on       = !rst_i;
      pmp_cfg_i    <= next_cfg;
      pmp_addr_i   <= next_addr;
      priv_lvl_i   <= priv;
      data_req_i   <= d_req;
      data_addr_i  <= d_addr;
      data_we_i    <= d_we;
      data_gnt_i   <= d_gnt;
      instr_req_i  <= f_req;
      instr_addr_i <= f_addr;
      instr_gnt_i  <= f_gnt;
      @(negedge clk);
      d_ok = access_allowed(tbl_on, priv, tbl_cfg, tbl_addr, d_addr,
                            d_we ? ACC_STORE : ACC_LOAD);
      f_ok = access_allowed(tbl_on, priv, tbl_cfg, tbl_addr, f_addr, ACC_FETCH);
      check_value("data_req_o", data_req_o, d_ok & d_req);
      check_value("data_gnt_o", data_gnt_o, d_ok & d_gnt);
      check_value("data_err_o", data_err_o, !d_ok & d_req);
      check_value("data_addr_o", data_addr_o, d_addr);
      check_value("instr_req_o", instr_req_o, f_ok & f_req);
      check_value("instr_gnt_o", instr_gnt_o, f_ok & f_gnt);
      check_value("instr_err_o", instr_err_o, !f_ok & f_req);
      check_value("instr_addr_o", instr_addr_o, f_addr);
   endtask

   task automatic random_access(
      input priv_lvl_e   priv,
      input logic [31:0] d_addr,
      input logic [31:0] f_addr
   );
      logic [31:0] strobes;
      strobes = rand_bits(5);
      apply_cycle(priv, strobes[0], d_addr, strobes[1], strobes[2],
                  strobes[3], f_addr, strobes[4]);
   endtask

   task automatic randomize_rules();
      logic [31:0] cfg_bits;
      logic [31:0] base_bits;
      for (int n = 0; n < `PMP_N_ENTRIES; n++)
      begin
         cfg_bits     = rand_bits(8);
         base_bits    = rand_bits(16);
         next_cfg[n]  = cfg_bits[7:0];
         // Bases packed in one window so TOR ranges overlap other rules
         next_addr[n] = {16'h0001, base_bits[15:0]};
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (rst_i !== 1'b0 && cycles < 10)
      begin
         @(negedge clk);
         cycles++;
      end
      if (rst_i !== 1'b0)
      begin
         failures++;
         $display("reset still asserted after %0d cycles", cycles);
      end
   endtask

   //////////////////////////////
   // Test phases
   //////////////////////////////
   task automatic after_reset_accesses();
      logic [31:0] d_addr;
      logic [31:0] f_addr;
      for (int i = 0; i < 24; i++)
      begin
         d_addr = rand_bits(32);
         f_addr = rand_bits(32);
         random_access((i < 12) ? PRIV_LVL_U : ((i < 18) ? PRIV_LVL_S : PRIV_LVL_M),
                       d_addr, f_addr);
      end
   endtask

   task automatic random_rule_sets();
      logic [31:0] pick;
      logic [31:0] d_addr;
      logic [31:0] f_addr;
      priv_lvl_e   priv;
      for (int set = 0; set < 24; set++)
      begin
         randomize_rules();
         for (int i = 0; i < 24; i++)
         begin
            pick   = rand_bits(4);
            d_addr = near_addr(next_addr[pick[3:0]]);
            pick   = rand_bits(4);
            f_addr = near_addr(next_addr[pick[3:0]]);
            priv   = random_priv();
            random_access(priv, d_addr, f_addr);
         end
      end
   endtask

   task automatic napot_size_sweep();
      logic [63:0] size;
      logic [31:0] lo;
      logic [31:0] perm_bits;
      logic [31:0] d_word;
      logic [31:0] f_word;
      for (int k = 0; k < 32; k++)
      begin
         // Region of 2^(k+1) words has k trailing ones above an aligned base
         size      = 64'd1 << (k + 1);
         lo        = rand_bits(32) & ~(size[31:0] - 32'd1);
         perm_bits = rand_bits(3);
         next_cfg  = '0;
         next_addr = '0;
         next_cfg[0].mode = PMP_NAPOT;
         next_cfg[0].perm = perm_bits[2:0];
         next_addr[0]     = lo | (size[32:1] - 32'd1);
         // All ones must never match even with every permission
         next_cfg[1].mode = PMP_NAPOT;
         next_cfg[1].perm = 3'b111;
         next_addr[1]     = '1;
         for (int i = 0; i < 10; i++)
         begin
            d_word = edge_word(lo, size);
            f_word = edge_word(lo, size);
            random_access(PRIV_LVL_U, {d_word[29:0], 2'b00}, {f_word[29:0], 2'b00});
         end
      end
   endtask

   task automatic gnt_stream();
      logic [31:0] bits;
      next_cfg  = '0;
      next_addr = '0;
      // Read-only TOR over words 0 to 0x3ff
      next_cfg[0].mode = PMP_TOR;
      next_cfg[0].perm = 3'b001;
      next_addr[0]     = 32'h0000_0400;
      for (int i = 0; i < 32; i++)
      begin
         bits = rand_bits(3);
         apply_cycle(PRIV_LVL_U, 1'b1, 32'h0000_0100, bits[0], bits[1],
                     1'b1, 32'h0000_0100, bits[2]);
      end
   endtask

   task automatic config_switch();
      next_cfg  = '0;
      next_addr = '0;
      apply_cycle(PRIV_LVL_U, 1'b1, 32'h0000_8000, 1'b1, 1'b1, 1'b1, 32'h0000_8000, 1'b1);
      next_cfg[3].mode = PMP_NA4;
      next_cfg[3].perm = 3'b111;
      next_addr[3]     = 32'h0000_2000;
      // New rule is on the inputs but not yet in the table
      apply_cycle(PRIV_LVL_U, 1'b1, 32'h0000_8000, 1'b1, 1'b1, 1'b1, 32'h0000_8000, 1'b1);
      check_value("data_err_o", data_err_o, 32'd1);
      apply_cycle(PRIV_LVL_U, 1'b1, 32'h0000_8000, 1'b1, 1'b1, 1'b1, 32'h0000_8000, 1'b1);
      check_value("data_err_o", data_err_o, 32'd0);
      check_value("instr_req_o", instr_req_o, 32'd1);
      next_cfg[3].mode = PMP_OFF;
      apply_cycle(PRIV_LVL_U, 1'b1, 32'h0000_8000, 1'b0, 1'b1, 1'b1, 32'h0000_8000, 1'b1);
      check_value("data_req_o", data_req_o, 32'd1);
      apply_cycle(PRIV_LVL_U, 1'b1, 32'h0000_8000, 1'b0, 1'b1, 1'b1, 32'h0000_8000, 1'b1);
      check_value("data_req_o", data_req_o, 32'd0);
      check_value("instr_err_o", instr_err_o, 32'd1);
   endtask

   initial
   begin
      lfsr_state   = 32'd45;
      checks       = 0;
      mismatches   = 0;
      failures     = 0;
      rst_i        = 1'b1;
      priv_lvl_i   = PRIV_LVL_U;
      next_addr    = '0;
      next_cfg     = '0;
      // An open TOR rule sits on the inputs while reset keeps the table empty
      next_cfg[0].mode = PMP_TOR;
      next_cfg[0].perm = 3'b111;
      next_addr[0]     = '1;
      pmp_addr_i   = next_addr;
      pmp_cfg_i    = next_cfg;
      data_req_i   = 1'b0;
      data_addr_i  = '0;
      data_we_i    = 1'b0;
      data_gnt_i   = 1'b0;
      instr_req_i  = 1'b0;
      instr_addr_i = '0;
      instr_gnt_i  = 1'b0;
      apply_cycle(PRIV_LVL_U, 1'b1, 32'h0000_1000, 1'b0, 1'b1, 1'b1, 32'h0000_2000, 1'b1);
      next_addr = '0;
      next_cfg  = '0;
      apply_cycle(PRIV_LVL_S, 1'b1, 32'h0000_1000, 1'b1, 1'b1, 1'b1, 32'h0000_2000, 1'b1);
      @(posedge clk);
      rst_i <= 1'b0;
      wait_reset_release();
      if (failures == 0)
      begin
         after_reset_accesses();
         random_rule_sets();
         napot_size_sweep();
         gnt_stream();
         config_switch();
      end
      $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
